/* project.f */
+incdir+design
+incdir+testbench
design/cast_pkg.sv
design/cast_pipe_stage.sv
design/cast_lzc.sv
design/cast_normalize.sv
design/cast_align.sv
design/cast_round.sv
design/cast_top.sv
testbench/tb_cast.sv

/* testbench/cast_model.svh */
`ifndef CAST_MODEL_SVH
`define CAST_MODEL_SVH

// ----------------------------------------------------------
// Reference model, results packed as {status, result}
// ----------------------------------------------------------

// Rounding decision from the bits below the kept LSB
function automatic logic round_inc(input logic lsb, input logic rnd, input logic stk,
                                   input logic neg, input roundmode_e rm);
  case (rm)
    RNE:     return rnd & (stk | lsb);  // Halfway goes to even
    RDN:     return neg & (rnd | stk);
    RUP:     return ~neg & (rnd | stk);
    RMM:     return rnd;
    default: return 1'b0;               // RTZ truncates
  endcase
endfunction

function automatic logic [36:0] model_i2f(input word_t v, input logic uns, input roundmode_e rm);
  logic        neg;
  logic [31:0] mag;
  logic [24:0] sig;   // Hidden bit plus fraction, one spare for the carry
  logic        rnd, stk;
  int          msb, sh;
  status_t     st;
  neg = v[31] & ~uns;
  mag = neg ? -v : v;
  st  = '0;
  msb = 0;
  if (mag == 0) return {st, 32'h0}; // Plus zero, exact
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) msb = i;
  end
  if (msb <= 23) begin
    sig = 25'(mag << (23 - msb));   // Fits, nothing lost
    rnd = 1'b0;
    stk = 1'b0;
  end else begin
    sh  = msb - 23;
    sig = 25'(mag >> sh);
    rnd = mag[sh-1];
    stk = (mag & ((32'h1 << (sh - 1)) - 1)) != 0;
  end
  sig = sig + 25'(round_inc(sig[0], rnd, stk, neg, rm));
  if (sig[24]) begin
    sig = sig >> 1;                 // Carry into the next binade
    msb++;
  end
  st[`CAST_ST_NX] = rnd | stk;
  return {st, neg, 8'(msb + `CAST_BIAS), sig[22:0]};
endfunction

function automatic logic [36:0] model_f2i(input word_t f, input logic uns, input roundmode_e rm);
  logic        sgn;
  logic [7:0]  ef;
  logic [22:0] mf;
  logic [63:0] sig, ip, mag;
  logic        rnd, stk;
  int          ex, sh;
  status_t     st;
  word_t       pos_max, neg_max;
  sgn     = f[31];
  ef      = f[30:23];
  mf      = f[22:0];
  st      = '0;
  pos_max = uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
  neg_max = uns ? 32'h0 : 32'h8000_0000;
  if (ef == 8'hFF && mf != 0) begin
    st[`CAST_ST_NV] = 1'b1;         // Any NaN, sign ignored
    return {st, pos_max};
  end
  if (ef == 0 && mf == 0) return {st, 32'h0};
  if (ef == 0) begin
    sig = 64'(mf);                  // Subnormal, no hidden bit
    ex  = -126;
  end else begin
    sig = 64'({1'b1, mf});
    ex  = int'(ef) - `CAST_BIAS;
  end
  // Infinity, or exponent at the top of the integer range
  if (ef == 8'hFF || ex >= (uns ? 32 : 31)) begin
    st[`CAST_ST_NV] = 1'b1;
    return {st, sgn ? neg_max : pos_max};
  end
  sh = 23 - ex;
  if (sh <= 0) begin
    ip  = sig << (-sh);
    rnd = 1'b0;
    stk = 1'b0;
  end else if (sh > 60) begin
    ip  = '0;                       // Far below one half
    rnd = 1'b0;
    stk = sig != 0;
  end else begin
    ip  = sig >> sh;
    rnd = sig[sh-1];
    stk = (sig & ((64'h1 << (sh - 1)) - 1)) != 0;
  end
  mag = ip + 64'(round_inc(ip[0], rnd, stk, sgn, rm));
  if (sgn && uns && mag != 0) begin
    st[`CAST_ST_NV] = 1'b1;         // Negative result not representable
    return {st, 32'h0};
  end
  st[`CAST_ST_NX] = rnd | stk;
  return {st, sgn ? word_t'(-mag) : mag[31:0]};
endfunction

`endif

/* testbench/tb_cast.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module tb_cast;
  import cast_pkg::*;

  `include "cast_model.svh"

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int N_I2F        = 300;
  localparam int N_F2I        = 300;
  localparam int N_SPECIAL    = 120;
  localparam int N_BP         = 300;
  localparam int TOTAL_ITEMS  = N_I2F + N_F2I + N_SPECIAL + N_BP;
  localparam int DRAIN_CYCLES = 200;  // Reset, bubbles and final drain
  localparam int BP_FACTOR    = 4;    // Random out_ready slows the stream
  localparam int TIMEOUT_NS   = (TOTAL_ITEMS * 3 + DRAIN_CYCLES) * CLK_PERIOD * BP_FACTOR;

  typedef struct packed {
    word_t       operand;
    cast_op_e    op;
    logic        uns;
    roundmode_e  rm;
    word_t       result;
    status_t     status;
    logic [31:0] cycle;   // Accept cycle
  } expect_t;

  logic       clk_i, rst_n_i;
  word_t      operand_i;
  cast_op_e   op_i;
  logic       is_unsigned_i;
  roundmode_e rnd_mode_i;
  logic       in_valid_i, in_ready_o;
  word_t      result_o;
  status_t    status_o;
  logic       out_valid_o, out_ready_i, busy_o;

  expect_t     exp_q[$];          // Scoreboard, in order
  logic [15:0] lfsr_state;
  logic [31:0] cycle_cnt = '0;
  logic        bp_enable = 1'b0;
  logic        latency_check = 1'b0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          failed_tests = 0;

  cast_top UUT (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .operand_i (operand_i), .op_i (op_i),
    .is_unsigned_i (is_unsigned_i), .rnd_mode_i (rnd_mode_i), .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o), .result_o (result_o), .status_o (status_o),
    .out_valid_o (out_valid_o), .out_ready_i (out_ready_i), .busy_o (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 32'd1;

  // ----------------------------------------------------------
  // Random source
  // ----------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};   // One step per bit
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic gen_item(input int kind, output word_t v, output cast_op_e op,
                          output logic uns, output roundmode_e rm);
    logic [31:0] r, sg, man, e;
    int          k;
    k = kind;
    if (kind == 3) begin
      take_bits(2, r);
      k = (r == 3) ? 2 : int'(r[1]);  // Mixed stream, mostly regular values
    end
    take_bits(1, r);
    uns = r[0];
    take_bits(3, r);
    rm = roundmode_e'(r % 5);
    take_bits(1, sg);
    take_bits(23, man);
    op = (k == 0) ? I2F : F2I;
    case (k)
      0: begin
        take_bits(32, r);
        take_bits(5, e);
        v = (e == 31) ? '0 : r >> e;  // Wide spread of magnitudes, zero now and then
        if (sg[0]) v = -v;
      end
      1: begin
        take_bits(1, r);
        take_bits(6, e);
        // Either the whole integer range or the rounding-rich band
        v = r[0] ? {sg[0], 8'(96 + e), man[22:0]} : {sg[0], 8'(120 + e[4:0]), man[22:0]};
      end
      default: begin
        take_bits(3, r);
        take_bits(5, e);
        case (r[2:0])
          0:       v = {sg[0], 8'hFF, man[22:0] | 23'h1};      // NaN, quiet or signalling
          1:       v = {sg[0], 8'hFF, 23'h0};                  // Infinity
          2:       v = {sg[0], 8'(158 + e), man[22:0]};        // Beyond the integer range
          3:       v = {sg[0], 8'h00, man[22:0]};              // Subnormal
          4:       v = {sg[0], 31'h0};                         // Signed zero
          5:       v = {1'b1, 8'(100 + e), man[22:0]};         // Negative, small to medium
          6:       v = {sg[0], 8'(157 + e[1:0]), man[22:0]};   // Around the range limit
          default: v = {sg[0], 8'(1 + e), man[22:0]};          // Tiny normal
        endcase
      end
    endcase
  endtask

  task automatic drive_ready();
    logic [31:0] r;
    if (bp_enable) begin
      take_bits(1, r);
      out_ready_i <= r[0];
    end else begin
      out_ready_i <= 1'b1;
    end
  endtask

  task automatic send_item(input word_t v, input cast_op_e op, input logic uns,
                           input roundmode_e rm);
    logic    accepted;
    expect_t e;
    operand_i     <= v;
    op_i          <= op;
    is_unsigned_i <= uns;
    rnd_mode_i    <= rm;
    in_valid_i    <= 1'b1;
    e.operand = v;
    e.op      = op;
    e.uns     = uns;
    e.rm      = rm;
    {e.status, e.result} = (op == F2I) ? model_f2i(v, uns, rm) : model_i2f(v, uns, rm);
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      accepted = in_ready_o;          // Value before this edge
      drive_ready();
    end
    e.cycle = cycle_cnt;
    exp_q.push_back(e);
  endtask

  task automatic run_test(input string name, input int kind, input int n, input logic bp);
    int          start_err;
    word_t       v;
    cast_op_e    op;
    logic        uns;
    roundmode_e  rm;
    logic [31:0] gap;
    start_err     = err_cnt;
    bp_enable     = bp;
    latency_check = ~bp;              // Fixed latency only with out_ready high
    @(posedge clk_i);
    drive_ready();
    for (int i = 0; i < n; i++) begin
      gen_item(kind, v, op, uns, rm);
      send_item(v, op, uns, rm);
      take_bits(3, gap);
      if (gap == 0) begin
        in_valid_i <= 1'b0;           // Bubble
        @(posedge clk_i);
        drive_ready();
      end
    end
    in_valid_i <= 1'b0;
    do begin
      @(posedge clk_i);
      drive_ready();
      @(negedge clk_i);
    end while (exp_q.size() != 0);
    test_cnt++;
    if (err_cnt != start_err) failed_tests++;
    $display("Test %s: %0d items, %0d errors", name, n, err_cnt - start_err);
  endtask

  // ----------------------------------------------------------
  // Output scoreboard and handshake checks
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    expect_t e;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("Error at %0t: output transfer with no item in flight", $time);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_cnt++;
        assert (result_o == e.result && status_o == e.status) else begin
          $display("Mismatch at %0t: %s uns=%0d rm=%0d operand=%h got %h/%b expected %h/%b",
                   $time, e.op.name(), e.uns, e.rm, e.operand, result_o, status_o,
                   e.result, e.status);
          err_cnt++;
        end
        if (latency_check) begin
          assert (cycle_cnt - e.cycle == 3) else begin
            $display("Mismatch at %0t: latency %0d cycles, expected 3", $time,
                     cycle_cnt - e.cycle);
            err_cnt++;
          end
        end
      end
    end
  end

  // Mid-cycle, all handshake signals and the queue are settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (busy_o == (exp_q.size() != 0)) else begin
        $display("Mismatch at %0t: busy_o=%b with %0d items in flight", $time, busy_o,
                 exp_q.size());
        err_cnt++;
      end
      // Three stages, so a stall needs three items and a blocked output
      assert (in_ready_o == !(exp_q.size() == 3 && !out_ready_i)) else begin
        $display("Mismatch at %0t: in_ready_o=%b, %0d in flight, out_ready_i=%b", $time,
                 in_ready_o, exp_q.size(), out_ready_i);
        err_cnt++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: run timed out after %0d ns, %0d items in flight", TIMEOUT_NS,
             exp_q.size());
    $display("Some tests failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    operand_i     = '0;
    op_i          = I2F;
    is_unsigned_i = 1'b0;
    rnd_mode_i    = RNE;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    rst_n_i       = 1'b0;
    lfsr_state    = 16'd62407;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      $display("Mismatch at %0t: after reset out_valid_o=%b busy_o=%b in_ready_o=%b", $time,
               out_valid_o, busy_o, in_ready_o);
      err_cnt++;
    end
    test_cnt++;
    if (err_cnt != 0) failed_tests++;
    $display("Test reset_idle: %0d errors", err_cnt);

    run_test("i2f_random", 0, N_I2F, 1'b0);
    run_test("f2i_random", 1, N_F2I, 1'b0);
    run_test("f2i_special", 2, N_SPECIAL, 1'b0);
    run_test("back_pressure", 3, N_BP, 1'b1);

    $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors", test_cnt,
             failed_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* design/cast_top.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module cast_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cast_pkg::word_t      operand_i,
  input  cast_pkg::cast_op_e   op_i,
  input  logic                 is_unsigned_i,
  input  cast_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output cast_pkg::word_t      result_o,
  output cast_pkg::status_t    status_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);
  import cast_pkg::*;

  localparam int unsigned CTRL_BITS = 2 + $bits(roundmode_e); // op, unsigned, mode
  localparam int unsigned S1_BITS   = `CAST_WORD_BITS + CTRL_BITS;
  localparam int unsigned S2_BITS   = 1 + 2 * `CAST_INT_EXP_BITS + `CAST_INT_MAN_BITS + 5
                                      + CTRL_BITS;
  localparam int unsigned S3_BITS   = `CAST_WORD_BITS + $bits(status_t);

  // Stage handshakes
  logic               s1_valid, s2_valid, s3_valid;
  logic               s1_ready, s2_ready, s3_ready;
  logic [S1_BITS-1:0] s1_data;
  logic [S2_BITS-1:0] s2_data;
  logic [S3_BITS-1:0] s3_data;

  // Stage 1 fields
  word_t              s1_operand;
  logic               s1_op, s1_uns;
  logic [2:0]         s1_rnd;

  // Normalizer outputs
  logic               n_sign, n_mant_zero, n_is_zero, n_is_inf, n_is_nan, n_is_snan;
  exp_t               n_exp, n_dst_exp;
  mant_t              n_mant;

  // Stage 2 fields
  logic               s2_sign, s2_mant_zero, s2_is_zero, s2_is_inf, s2_is_nan, s2_is_snan;
  exp_t               s2_exp, s2_dst_exp;
  mant_t              s2_mant;
  logic               s2_op, s2_uns;
  logic [2:0]         s2_rnd;

  // Align and round
  logic [`CAST_EXP_BITS-1:0] a_final_exp;
  logic [`CAST_MAN_BITS-1:0] a_final_mant;
  word_t                     a_final_int;
  logic [1:0]                a_fp_rs, a_int_rs;
  logic                      a_of_before;
  word_t                     r_result;
  status_t                   r_status;

  // ----------------------------------------------------------
  // Stage 1 registers the raw request
  // ----------------------------------------------------------
  cast_pipe_stage #(.PAYLOAD_BITS(S1_BITS)) i_stage1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (in_valid_i),
    .ready_o (s1_ready),
    .data_i  ({operand_i, op_i, is_unsigned_i, rnd_mode_i}),
    .valid_o (s1_valid),
    .ready_i (s2_ready),
    .data_o  (s1_data)
  );
  assign {s1_operand, s1_op, s1_uns, s1_rnd} = s1_data;

  cast_normalize i_normalize (
    .operand_i (s1_operand), .op_i (cast_op_e'(s1_op)), .is_unsigned_i (s1_uns),
    .sign_o (n_sign), .exp_o (n_exp), .dst_exp_o (n_dst_exp), .mant_o (n_mant),
    .mant_zero_o (n_mant_zero), .is_zero_o (n_is_zero), .is_inf_o (n_is_inf),
    .is_nan_o (n_is_nan), .is_snan_o (n_is_snan)
  );

  // ----------------------------------------------------------
  // Stage 2 holds the normalized operand
  // ----------------------------------------------------------
  cast_pipe_stage #(.PAYLOAD_BITS(S2_BITS)) i_stage2 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s1_valid),
    .ready_o (s2_ready),
    .data_i  ({n_sign, n_exp, n_dst_exp, n_mant, n_mant_zero, n_is_zero, n_is_inf,
               n_is_nan, n_is_snan, s1_op, s1_uns, s1_rnd}),
    .valid_o (s2_valid),
    .ready_i (s3_ready),
    .data_o  (s2_data)
  );
  assign {s2_sign, s2_exp, s2_dst_exp, s2_mant, s2_mant_zero, s2_is_zero, s2_is_inf,
          s2_is_nan, s2_is_snan, s2_op, s2_uns, s2_rnd} = s2_data;

  cast_align i_align (
    .op_i (cast_op_e'(s2_op)), .is_unsigned_i (s2_uns), .exp_i (s2_exp),
    .dst_exp_i (s2_dst_exp), .mant_i (s2_mant), .is_inf_i (s2_is_inf),
    .final_exp_o (a_final_exp), .final_mant_o (a_final_mant), .final_int_o (a_final_int),
    .fp_rs_o (a_fp_rs), .int_rs_o (a_int_rs), .of_before_o (a_of_before),
    .uf_before_o ()  // Underflow already folded into sticky
  );

  cast_round i_round (
    .op_i (cast_op_e'(s2_op)), .is_unsigned_i (s2_uns), .rnd_mode_i (roundmode_e'(s2_rnd)),
    .sign_i (s2_sign), .mant_zero_i (s2_mant_zero), .is_zero_i (s2_is_zero),
    .is_inf_i (s2_is_inf), .is_nan_i (s2_is_nan), .is_snan_i (s2_is_snan),
    .final_exp_i (a_final_exp), .final_mant_i (a_final_mant), .final_int_i (a_final_int),
    .fp_rs_i (a_fp_rs), .int_rs_i (a_int_rs), .of_before_i (a_of_before),
    .result_o (r_result), .status_o (r_status)
  );

  // ----------------------------------------------------------
  // Stage 3 drives the outputs
  // ----------------------------------------------------------
  cast_pipe_stage #(.PAYLOAD_BITS(S3_BITS)) i_stage3 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s2_valid),
    .ready_o (s3_ready),
    .data_i  ({r_result, r_status}),
    .valid_o (s3_valid),
    .ready_i (out_ready_i),
    .data_o  (s3_data)
  );
  assign {result_o, status_o} = s3_data;

  assign in_ready_o  = s1_ready;                       // Combinational ready chain
  assign out_valid_o = s3_valid;
  assign busy_o      = s1_valid | s2_valid | s3_valid; // Anything in flight

endmodule

/* design/cast_round.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module cast_round (
  input  cast_pkg::cast_op_e        op_i,
  input  logic                      is_unsigned_i,
  input  cast_pkg::roundmode_e      rnd_mode_i,
  input  logic                      sign_i,
  input  logic                      mant_zero_i,
  input  logic                      is_zero_i,
  input  logic                      is_inf_i,
  input  logic                      is_nan_i,
  input  logic                      is_snan_i,
  input  logic [`CAST_EXP_BITS-1:0] final_exp_i,
  input  logic [`CAST_MAN_BITS-1:0] final_mant_i,
  input  cast_pkg::word_t           final_int_i,
  input  logic [1:0]                fp_rs_i,
  input  logic [1:0]                int_rs_i,
  input  logic                      of_before_i,
  output cast_pkg::word_t           result_o,
  output cast_pkg::status_t         status_o
);
  import cast_pkg::*;

  logic       to_int;
  logic       eff_sign;
  logic       any_nan;
  logic [1:0] rs_bits;
  word_t      pre_round_abs, rounded_abs;
  logic       round_up;
  logic       of_after;
  word_t      fp_result, int_result, int_regular, int_special;
  logic       int_is_special;
  status_t    fp_status, int_status;

  assign to_int   = (op_i == F2I);
  assign eff_sign = sign_i & ~is_zero_i;    // Signed zero rounds like plus zero
  assign any_nan  = is_nan_i | is_snan_i;   // Signalling NaNs count too

  // ----------------------------------------------------------
  // Rounding of the absolute value
  // ----------------------------------------------------------
  assign pre_round_abs = to_int ? final_int_i : {1'b0, final_exp_i, final_mant_i};
  assign rs_bits       = to_int ? int_rs_i : fp_rs_i;

  always_comb begin
    unique case (rnd_mode_i)
      RNE:     round_up = rs_bits[1] & (rs_bits[0] | pre_round_abs[0]); // Ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_bits) & eff_sign;
      RUP:     round_up = (|rs_bits) & ~eff_sign;
      RMM:     round_up = rs_bits[1];             // Ties away
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + word_t'(round_up);

  // ----------------------------------------------------------
  // Float result
  // ----------------------------------------------------------
  assign of_after  = (rounded_abs[`CAST_WORD_BITS-2 -: `CAST_EXP_BITS] == `CAST_QNAN_EXP);
  // Integer zero has no leading one, force plus zero
  assign fp_result = mant_zero_i ? '0 : {eff_sign, rounded_abs[`CAST_WORD_BITS-2:0]};

  // ----------------------------------------------------------
  // Integer result and special cases
  // ----------------------------------------------------------
  assign int_regular = eff_sign ? word_t'(-rounded_abs) : rounded_abs;

  always_comb begin
    int_special = {is_unsigned_i, {(`CAST_WORD_BITS-1){1'b1}}}; // Positive max
    if (eff_sign && !any_nan) begin
      int_special = ~int_special; // Negative max or zero for unsigned
    end
  end

  // Negative to unsigned is invalid unless it rounds to zero
  assign int_is_special = any_nan | is_inf_i | of_before_i |
                          (eff_sign & is_unsigned_i & (int_regular != '0));

  assign int_result = int_is_special ? int_special : int_regular;

  // ----------------------------------------------------------
  // Status
  // ----------------------------------------------------------
  // DZ, OF and UF never arise here
  always_comb begin
    fp_status              = '0;
    fp_status[`CAST_ST_NV] = of_before_i | of_after; // I2F overflow is invalid
    fp_status[`CAST_ST_NX] = |fp_rs_i;

    int_status = '0;
    if (int_is_special) begin
      int_status[`CAST_ST_NV] = 1'b1; // Only NV on special results
    end else begin
      int_status[`CAST_ST_NX] = |int_rs_i;
    end
  end

  assign result_o = to_int ? int_result : fp_result;
  assign status_o = to_int ? int_status : fp_status;

endmodule

/* design/cast_align.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module cast_align (
  input  cast_pkg::cast_op_e         op_i,
  input  logic                       is_unsigned_i,
  input  cast_pkg::exp_t             exp_i,
  input  cast_pkg::exp_t             dst_exp_i,
  input  cast_pkg::mant_t            mant_i,
  input  logic                       is_inf_i,
  output logic [`CAST_EXP_BITS-1:0]  final_exp_o,
  output logic [`CAST_MAN_BITS-1:0]  final_mant_o,
  output cast_pkg::word_t            final_int_o,
  output logic [1:0]                 fp_rs_o,   // Round, sticky
  output logic [1:0]                 int_rs_o,
  output logic                       of_before_o,
  output logic                       uf_before_o
);
  import cast_pkg::*;

  localparam int unsigned SHIFT_BITS = 2 * `CAST_INT_MAN_BITS + 1;
  localparam int unsigned FP_STICKY  = 2 * `CAST_INT_MAN_BITS - `CAST_MAN_BITS - 1;
  localparam int unsigned INT_STICKY = 2 * `CAST_INT_MAN_BITS - `CAST_WORD_BITS;

  logic [SHIFT_BITS-1:0] preshift_mant;
  logic [SHIFT_BITS-1:0] dest_mant;
  shamt_t                denorm_shamt;

  // ----------------------------------------------------------
  // Shift amount and range checks
  // ----------------------------------------------------------
  always_comb begin
    final_exp_o   = dst_exp_i[`CAST_EXP_BITS-1:0]; // Lower bits only
    preshift_mant = {mant_i, {(`CAST_INT_MAN_BITS + 1){1'b0}}}; // Left end of shifter
    denorm_shamt  = '0;
    of_before_o   = 1'b0;
    uf_before_o   = 1'b0;

    if (op_i == F2I) begin
      // Binary point lands right of the integer LSB
      denorm_shamt = shamt_t'(exp_t'(`CAST_WORD_BITS - 1) - exp_i);
      // Unsigned range is one bit wider
      if (is_inf_i || exp_i >= exp_t'(`CAST_WORD_BITS - 1 + is_unsigned_i)) begin
        denorm_shamt = '0;
        of_before_o  = 1'b1;
      end else if (exp_i < -1) begin
        denorm_shamt = shamt_t'(`CAST_WORD_BITS + 1); // Everything into sticky
        uf_before_o  = 1'b1;
      end
    end else if (dst_exp_i >= exp_t'((1 << `CAST_EXP_BITS) - 1)) begin
      // Saturate to the largest normal with R and S set
      final_exp_o   = `CAST_EXP_BITS'((1 << `CAST_EXP_BITS) - 2);
      preshift_mant = '1;
      of_before_o   = 1'b1;
    end
  end

  assign dest_mant = preshift_mant >> denorm_shamt;

  // ----------------------------------------------------------
  // Extraction
  // ----------------------------------------------------------
  // Hidden bit at the top is dropped for the float result
  assign {final_mant_o, fp_rs_o[1]} = dest_mant[SHIFT_BITS-2 -: `CAST_MAN_BITS+1];
  assign {final_int_o, int_rs_o[1]} = dest_mant[SHIFT_BITS-1 -: `CAST_WORD_BITS+1];

  assign fp_rs_o[0]  = |dest_mant[FP_STICKY-1:0];  // Below round bit
  assign int_rs_o[0] = |dest_mant[INT_STICKY-1:0];

endmodule

/* design/cast_normalize.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module cast_normalize (
  input  cast_pkg::word_t    operand_i,
  input  cast_pkg::cast_op_e op_i,
  input  logic               is_unsigned_i,
  output logic               sign_o,
  output cast_pkg::exp_t     exp_o,     // Unbiased
  output cast_pkg::exp_t     dst_exp_o, // Rebiased to binary32
  output cast_pkg::mant_t    mant_o,    // MSB aligned
  output logic               mant_zero_o,
  output logic               is_zero_o,
  output logic               is_inf_o,
  output logic               is_nan_o,
  output logic               is_snan_o
);
  import cast_pkg::*;

  logic                      is_float;
  logic [`CAST_EXP_BITS-1:0] exp_field;
  logic [`CAST_MAN_BITS-1:0] man_field;
  logic                      exp_max, exp_min, man_zero;
  logic                      is_normal, is_subnormal;
  logic                      int_sign;
  mant_t                     int_mant, enc_mant;
  shamt_t                    lz_count;
  exp_t                      fp_exp, int_exp;

  // ----------------------------------------------------------
  // Float classification
  // ----------------------------------------------------------
  assign is_float  = (op_i == F2I);
  assign exp_field = operand_i[`CAST_WORD_BITS-2 -: `CAST_EXP_BITS];
  assign man_field = operand_i[`CAST_MAN_BITS-1:0];
  assign exp_max   = (exp_field == `CAST_QNAN_EXP);
  assign exp_min   = (exp_field == '0);
  assign man_zero  = (man_field == '0);

  assign is_normal    = ~exp_min & ~exp_max;
  assign is_subnormal = exp_min & ~man_zero;

  // Class bits only mean something for float sources
  assign is_zero_o = is_float & exp_min & man_zero;
  assign is_inf_o  = is_float & exp_max & man_zero;
  assign is_nan_o  = is_float & exp_max & ~man_zero;
  assign is_snan_o = is_nan_o & ~man_field[`CAST_QNAN_BIT]; // Quiet bit clear

  // ----------------------------------------------------------
  // Mantissa selection
  // ----------------------------------------------------------
  // Only signed integers can be negative
  assign int_sign = operand_i[`CAST_WORD_BITS-1] & ~is_unsigned_i;
  assign int_mant = int_sign ? mant_t'(-operand_i) : operand_i; // Magnitude

  // Hidden bit joins the fraction, zero padded on the left
  assign enc_mant = is_float ? mant_t'({is_normal, man_field}) : int_mant;

  cast_lzc i_lzc (
    .value_i   (enc_mant),
    .count_o   (lz_count),
    .is_zero_o (mant_zero_o)
  );

  assign mant_o = enc_mant << lz_count; // Renormalize subnormals and integers

  // ----------------------------------------------------------
  // Exponents
  // ----------------------------------------------------------
  // Subnormals use exponent 1, the LZC shift is compensated
  assign fp_exp = exp_t'(exp_field) + exp_t'(is_subnormal) - exp_t'(`CAST_BIAS)
                  - exp_t'(lz_count) + exp_t'(`CAST_INT_MAN_BITS - 1 - `CAST_MAN_BITS);
  assign int_exp = exp_t'(`CAST_INT_MAN_BITS - 1) - exp_t'(lz_count);

  assign sign_o    = is_float ? operand_i[`CAST_WORD_BITS-1] : int_sign;
  assign exp_o     = is_float ? fp_exp : int_exp;
  assign dst_exp_o = exp_o + exp_t'(`CAST_BIAS);

endmodule

/* design/cast_lzc.sv */
`timescale 1ns/100ps
`include "cast_defs.svh"

module cast_lzc (
  input  cast_pkg::mant_t  value_i,
  output cast_pkg::shamt_t count_o,
  output logic             is_zero_o
);
  import cast_pkg::*;

  // Priority search from LSB upwards, the highest set bit wins
  always_comb begin
    count_o = '0;
    for (int i = 0; i < `CAST_INT_MAN_BITS; i++) begin
      if (value_i[i]) begin
        count_o = shamt_t'(`CAST_INT_MAN_BITS - 1 - i);
      end
    end
  end

  assign is_zero_o = ~|value_i; // Count is meaningless then

endmodule

/* design/cast_pipe_stage.sv */
`timescale 1ns/100ps

module cast_pipe_stage #(
  parameter int unsigned PAYLOAD_BITS = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Upstream side
  input  logic                    valid_i,
  output logic                    ready_o,
  input  logic [PAYLOAD_BITS-1:0] data_i,
  // Downstream side
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic [PAYLOAD_BITS-1:0] data_o
);

  logic                    valid_q;
  logic [PAYLOAD_BITS-1:0] data_q;

  // Advance when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i; // Bubble in when nothing arrives
    end
  end

  // Payload only loads on a real transfer
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* design/cast_pkg.sv */
`include "cast_defs.svh"

package cast_pkg;

  // ----------------------------------------------------------
  // Datapath vectors
  // ----------------------------------------------------------
  typedef logic [`CAST_WORD_BITS-1:0]           word_t;   // Operand or result
  typedef logic [`CAST_INT_MAN_BITS-1:0]        mant_t;   // Internal mantissa
  typedef logic signed [`CAST_INT_EXP_BITS-1:0] exp_t;    // Unbiased or rebiased exponent
  typedef logic [`CAST_SHAMT_BITS-1:0]          shamt_t;  // Shift amount
  typedef logic [4:0]                           status_t; // NV DZ OF UF NX

  // Rounding modes, RISC-V encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // Conversion direction
  typedef enum logic {
    I2F = 1'b0,
    F2I = 1'b1
  } cast_op_e;

endpackage

/* design/cast_defs.svh */
`ifndef CAST_DEFS_SVH
`define CAST_DEFS_SVH

// ----------------------------------------------------------
// Widths and formats
// ----------------------------------------------------------
`define CAST_WORD_BITS    32  // Operand and result width
`define CAST_EXP_BITS     8   // binary32 exponent
`define CAST_MAN_BITS     23  // binary32 fraction
`define CAST_BIAS         127
`define CAST_INT_MAN_BITS 32  // Holds a whole integer or hidden bit plus fraction
`define CAST_INT_EXP_BITS 10  // Signed, reaches the smallest subnormal
`define CAST_SHAMT_BITS   6

// Status word bit positions
`define CAST_ST_NV 4
`define CAST_ST_DZ 3
`define CAST_ST_OF 2
`define CAST_ST_UF 1
`define CAST_ST_NX 0

// Quiet NaN fields
`define CAST_QNAN_EXP 8'hFF
`define CAST_QNAN_BIT 22      // Set in the fraction of a quiet NaN

`endif
